// ==== Makefile ====
SRCS := $(shell grep -v '^+' sim.f)

obj_dir/Vtb_ooo_core: sim.f ooo_defs.svh $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_ooo_core -f sim.f -o Vtb_ooo_core

.PHONY: run clean

run: obj_dir/Vtb_ooo_core
	@out=$$(./obj_dir/Vtb_ooo_core 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

// ==== core_ctrl_wb.sv ====
`default_nettype none

`include "ooo_defs.svh"

module core_ctrl_wb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADDR_W-1:0] wb_adr,
    input  ooo_pkg::word_t        wb_dat_w,
    output ooo_pkg::word_t        wb_dat_r,
    output logic                  wb_ack,
    input  ooo_pkg::commit_t      retire,
    output logic                  enable
);

    localparam logic [`WB_ADDR_W-1:0] ADDR_CTRL    = `WB_ADDR_W'(0);
    localparam logic [`WB_ADDR_W-1:0] ADDR_RETIRED = `WB_ADDR_W'(1);
    localparam logic [`WB_ADDR_W-1:0] ADDR_TAKEN   = `WB_ADDR_W'(2);

    ooo_pkg::word_t retired_cnt;
    ooo_pkg::word_t taken_cnt;
    logic           req;

    assign req = wb_cyc && wb_stb && !wb_ack;   // Ignores the access already being acked

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_ack      <= 1'b0;
            enable      <= 1'b0;
            retired_cnt <= '0;
            taken_cnt   <= '0;
        end else begin
            wb_ack <= req;
            if (retire.valid) begin
                retired_cnt <= retired_cnt + 1'b1;
                if (retire.taken) taken_cnt <= taken_cnt + 1'b1;
            end
            // Counter clears take priority over a same-cycle commit
            if (req && wb_we) begin
                case (wb_adr)
                    ADDR_CTRL:    enable      <= wb_dat_w[0];
                    ADDR_RETIRED: retired_cnt <= '0;
                    ADDR_TAKEN:   taken_cnt   <= '0;
                    default:      enable      <= enable;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                ADDR_CTRL:    wb_dat_r <= `XLEN'(enable);
                ADDR_RETIRED: wb_dat_r <= retired_cnt;
                ADDR_TAKEN:   wb_dat_r <= taken_cnt;
                default:      wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== int_alu.sv ====
`default_nettype none

`include "ooo_defs.svh"

module int_alu (
    input  logic            clk,
    input  logic            rst,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb
);

    localparam int SHAMT_W = $clog2(`XLEN);

    ooo_pkg::word_t     result;
    logic [SHAMT_W-1:0] shamt;

    assign shamt = issue.b[SHAMT_W-1:0];

    always_comb begin
        case (issue.op)
            ooo_pkg::OP_ADD:  result = issue.a + issue.b;
            ooo_pkg::OP_SUB:  result = issue.a - issue.b;
            ooo_pkg::OP_AND:  result = issue.a & issue.b;
            ooo_pkg::OP_OR:   result = issue.a | issue.b;
            ooo_pkg::OP_XOR:  result = issue.a ^ issue.b;
            ooo_pkg::OP_SLT:  result = `XLEN'($signed(issue.a) < $signed(issue.b));
            ooo_pkg::OP_SLTU: result = `XLEN'(issue.a < issue.b);
            ooo_pkg::OP_SLL:  result = issue.a << shamt;
            ooo_pkg::OP_SRL:  result = issue.a >> shamt;
            // Branches report 1 when taken
            ooo_pkg::OP_BEQ:  result = `XLEN'(issue.a == issue.b);
            ooo_pkg::OP_BNE:  result = `XLEN'(issue.a != issue.b);
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        cdb.tag   <= issue.tag;
        cdb.value <= result;
    end

endmodule

`default_nettype wire

// ==== ooo_core_top.sv ====
`default_nettype none

`include "ooo_defs.svh"

module ooo_core_top (
    input  logic                  clk,
    input  logic                  rst,
    input  ooo_pkg::dispatch_t    disp,
    output logic                  dispatch_ready,
    output ooo_pkg::commit_t      commit,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADDR_W-1:0] wb_adr,
    input  ooo_pkg::word_t        wb_dat_w,
    output ooo_pkg::word_t        wb_dat_r,
    output logic                  wb_ack
);

    logic              rob_full;
    logic              rs_has_space;
    logic              enable;
    logic              disp_fire;
    logic              rs_fire;
    ooo_pkg::tag_t     alloc_tag;
    ooo_pkg::reg_idx_t rd_alloc;
    ooo_pkg::operand_t src1;
    ooo_pkg::operand_t src2;
    ooo_pkg::operand_t fwd1;
    ooo_pkg::operand_t fwd2;
    ooo_pkg::issue_t   issue;
    ooo_pkg::cdb_t     cdb;

    assign dispatch_ready = !rob_full && rs_has_space && enable;
    assign disp_fire      = disp.valid && dispatch_ready;
    assign rs_fire        = disp_fire && (disp.op != ooo_pkg::OP_LUI); // LUI done in ROB

    // Branches never claim a destination register
    assign rd_alloc = ((disp.op == ooo_pkg::OP_BEQ) || (disp.op == ooo_pkg::OP_BNE)) ?
                      '0 : disp.rd;

    reorder_buffer reorder_buffer_inst (
        .clk       (clk),
        .rst       (rst),
        .disp      (disp),
        .disp_fire (disp_fire),
        .alloc_tag (alloc_tag),
        .full      (rob_full),
        .src1_tag  (src1.tag),
        .src2_tag  (src2.tag),
        .src1_fwd  (fwd1),
        .src2_fwd  (fwd2),
        .cdb       (cdb),
        .retire    (commit)
    );

    rename_regfile rename_regfile_inst (
        .clk        (clk),
        .rst        (rst),
        .rs1        (disp.rs1),
        .rs2        (disp.rs2),
        .src1       (src1),
        .src2       (src2),
        .rd_alloc   (rd_alloc),
        .alloc_tag  (alloc_tag),
        .alloc_fire (disp_fire),
        .retire     (commit),
        .fwd1       (fwd1),
        .fwd2       (fwd2)
    );

    reservation_station reservation_station_inst (
        .clk       (clk),
        .rst       (rst),
        .disp      (disp),
        .disp_fire (rs_fire),
        .disp_tag  (alloc_tag),
        .opnd1     (src1),
        .opnd2     (src2),
        .cdb       (cdb),
        .has_space (rs_has_space),
        .issue     (issue)
    );

    int_alu int_alu_inst (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .cdb   (cdb)
    );

    core_ctrl_wb core_ctrl_wb_inst (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .retire   (commit),
        .enable   (enable)
    );

endmodule

`default_nettype wire

// ==== ooo_defs.svh ====
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Tag 0 of the reorder buffer stands for no producer
`define ROB_DEPTH 8
`define TAG_W     3

`define NUM_REGS  32
`define XLEN      32

// Reservation station entries
`define RS_DEPTH  4

// Word address on the control bus
`define WB_ADDR_W 4

`endif

// ==== ooo_pkg.sv ====
`default_nettype none

`include "ooo_defs.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_LUI,
        OP_BEQ,
        OP_BNE
    } op_e;

    typedef logic [`TAG_W-1:0]             tag_t;
    typedef logic [$clog2(`NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [`XLEN-1:0]              word_t;

    typedef struct packed {
        logic     valid;
        op_e      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        word_t    imm;
    } dispatch_t;

    // Tag stays the producer even once ready is set
    typedef struct packed {
        word_t value;
        tag_t  tag;
        logic  ready;
    } operand_t;

    typedef struct packed {
        logic  valid;
        op_e   op;
        tag_t  tag;
        word_t a;
        word_t b;
    } issue_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t value;     // Nonzero for a taken branch
    } cdb_t;

    typedef struct packed {
        logic     valid;
        tag_t     tag;
        reg_idx_t rd;
        word_t    value;
        logic     is_branch;
        logic     taken;
    } commit_t;

endpackage

`default_nettype wire

// ==== rename_regfile.sv ====
`default_nettype none

`include "ooo_defs.svh"

module rename_regfile (
    input  logic              clk,
    input  logic              rst,
    input  ooo_pkg::reg_idx_t rs1,
    input  ooo_pkg::reg_idx_t rs2,
    output ooo_pkg::operand_t src1,
    output ooo_pkg::operand_t src2,
    input  ooo_pkg::reg_idx_t rd_alloc,
    input  ooo_pkg::tag_t     alloc_tag,
    input  logic              alloc_fire,
    input  ooo_pkg::commit_t  retire,
    input  ooo_pkg::operand_t fwd1,
    input  ooo_pkg::operand_t fwd2
);

    ooo_pkg::word_t regs     [`NUM_REGS];
    ooo_pkg::tag_t  producer [`NUM_REGS];   // 0 when the register holds its value

    function automatic ooo_pkg::operand_t merge(input ooo_pkg::word_t    v,
                                                input ooo_pkg::tag_t     t,
                                                input ooo_pkg::operand_t fwd);
        ooo_pkg::operand_t o;
        o.tag = t;
        if (t == '0) begin
            o.value = v;
            o.ready = 1'b1;
        end else begin
            o.value = fwd.value;  // ROB may already hold the result
            o.ready = fwd.ready;
        end
        return o;
    endfunction

    always_comb begin
        src1 = merge(regs[rs1], producer[rs1], fwd1);
        src2 = merge(regs[rs2], producer[rs2], fwd2);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i]     <= '0;
                producer[i] <= '0;
            end
        end else begin
            if (retire.valid && (retire.rd != '0)) begin
                regs[retire.rd] <= retire.value;
                if (producer[retire.rd] == retire.tag) begin
                    producer[retire.rd] <= '0;
                end
            end
            // Newer allocation of the same rd overrides the clear above
            if (alloc_fire && (rd_alloc != '0)) begin
                producer[rd_alloc] <= alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`default_nettype none

`include "ooo_defs.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t disp,
    input  logic               disp_fire,
    output ooo_pkg::tag_t      alloc_tag,
    output logic               full,
    input  ooo_pkg::tag_t      src1_tag,
    input  ooo_pkg::tag_t      src2_tag,
    output ooo_pkg::operand_t  src1_fwd,
    output ooo_pkg::operand_t  src2_fwd,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::commit_t   retire
);

    ooo_pkg::op_e      rob_op    [`ROB_DEPTH];
    ooo_pkg::reg_idx_t rob_rd    [`ROB_DEPTH];
    ooo_pkg::word_t    rob_value [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] rob_done;

    ooo_pkg::tag_t     head;
    ooo_pkg::tag_t     tail;
    logic [`TAG_W-1:0] count;
    logic              head_branch;

    function automatic logic is_branch(input ooo_pkg::op_e op);
        return (op == ooo_pkg::OP_BEQ) || (op == ooo_pkg::OP_BNE);
    endfunction

    // Wraps from the last entry back to 1, skipping tag 0
    function automatic ooo_pkg::tag_t next_tag(input ooo_pkg::tag_t t);
        if (t == ooo_pkg::tag_t'(`ROB_DEPTH - 1)) begin
            return ooo_pkg::tag_t'(1);
        end
        return t + ooo_pkg::tag_t'(1);
    endfunction

    function automatic ooo_pkg::operand_t lookup(input ooo_pkg::tag_t t);
        ooo_pkg::operand_t o;
        o.tag   = t;
        o.ready = (t != '0) && rob_done[t];
        o.value = rob_value[t];
        return o;
    endfunction

    assign alloc_tag = tail;
    assign full      = (count == `TAG_W'(`ROB_DEPTH - 1));

    always_comb begin
        src1_fwd = lookup(src1_tag);
        src2_fwd = lookup(src2_tag);
    end

    always_comb begin
        head_branch      = is_branch(rob_op[head]);
        retire.valid     = (count != '0) && rob_done[head];
        retire.tag       = head;
        retire.rd        = rob_rd[head];
        retire.value     = rob_value[head];
        retire.is_branch = head_branch;
        retire.taken     = head_branch && (rob_value[head] != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head     <= ooo_pkg::tag_t'(1);
            tail     <= ooo_pkg::tag_t'(1);
            count    <= '0;
            rob_done <= '0;
        end else begin
            if (retire.valid) begin
                head <= next_tag(head);
            end
            if (disp_fire) begin
                tail           <= next_tag(tail);
                rob_done[tail] <= (disp.op == ooo_pkg::OP_LUI); // Complete on entry
            end
            if (cdb.valid) begin
                rob_done[cdb.tag] <= 1'b1;
            end
            case ({disp_fire, retire.valid})
                2'b10:   count <= count + `TAG_W'(1);
                2'b01:   count <= count - `TAG_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (disp_fire) begin
            rob_op[tail]    <= disp.op;
            rob_rd[tail]    <= is_branch(disp.op) ? '0 : disp.rd; // Branches write nothing
            rob_value[tail] <= disp.imm;
        end
        if (cdb.valid) begin
            rob_value[cdb.tag] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`default_nettype none

`include "ooo_defs.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::dispatch_t disp,
    input  logic               disp_fire,
    input  ooo_pkg::tag_t      disp_tag,
    input  ooo_pkg::operand_t  opnd1,
    input  ooo_pkg::operand_t  opnd2,
    input  ooo_pkg::cdb_t      cdb,
    output logic               has_space,
    output ooo_pkg::issue_t    issue
);

    localparam int IDX_W = $clog2(`RS_DEPTH);

    typedef struct packed {
        logic              valid;
        ooo_pkg::op_e      op;
        ooo_pkg::tag_t     tag;
        ooo_pkg::operand_t opnd1;
        ooo_pkg::operand_t opnd2;
    } rs_entry_t;

    rs_entry_t             entry [`RS_DEPTH];
    logic [`RS_DEPTH-1:0]  older [`RS_DEPTH];  // older[i][j] set when i came before j
    logic [`RS_DEPTH-1:0]  ready_vec;
    logic [`RS_DEPTH-1:0]  free_vec;
    logic [`RS_DEPTH-1:0]  pick;
    logic [IDX_W-1:0]      issue_idx;
    logic [IDX_W-1:0]      free_idx;
    ooo_pkg::operand_t     new_opnd1;
    ooo_pkg::operand_t     new_opnd2;

    function automatic ooo_pkg::operand_t snoop(input ooo_pkg::operand_t o,
                                                input ooo_pkg::cdb_t     c);
        ooo_pkg::operand_t r;
        r = o;
        if (c.valid && !o.ready && (o.tag == c.tag)) begin
            r.value = c.value;
            r.ready = 1'b1;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready_vec[i] = entry[i].valid && entry[i].opnd1.ready && entry[i].opnd2.ready;
            free_vec[i]  = !entry[i].valid;
        end
        // Oldest ready entry has no older ready entry
        for (int i = 0; i < `RS_DEPTH; i++) begin
            pick[i] = ready_vec[i];
            for (int j = 0; j < `RS_DEPTH; j++) begin
                if (ready_vec[j] && older[j][i]) begin
                    pick[i] = 1'b0;
                end
            end
        end
        issue_idx = '0;
        free_idx  = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (pick[i]) issue_idx = IDX_W'(i);
            if (free_vec[i]) free_idx = IDX_W'(i);
        end
    end

    assign has_space = |free_vec;

    always_comb begin
        issue.valid = |pick;
        issue.op    = entry[issue_idx].op;
        issue.tag   = entry[issue_idx].tag;
        issue.a     = entry[issue_idx].opnd1.value;
        issue.b     = entry[issue_idx].opnd2.value;
    end

    always_comb begin
        new_opnd2 = opnd2;
        if (disp.use_imm) begin
            new_opnd2.value = disp.imm;
            new_opnd2.tag   = '0;
            new_opnd2.ready = 1'b1;
        end
        new_opnd1 = snoop(opnd1, cdb);    // Same-cycle broadcast
        new_opnd2 = snoop(new_opnd2, cdb);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entry[i].valid <= 1'b0;
                older[i]       <= '0;
            end
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                entry[i].opnd1 <= snoop(entry[i].opnd1, cdb);
                entry[i].opnd2 <= snoop(entry[i].opnd2, cdb);
            end
            if (issue.valid) begin
                entry[issue_idx].valid <= 1'b0;
            end
            if (disp_fire) begin
                entry[free_idx] <= '{valid: 1'b1, op: disp.op, tag: disp_tag,
                                     opnd1: new_opnd1, opnd2: new_opnd2};
                for (int j = 0; j < `RS_DEPTH; j++) begin
                    older[j][free_idx] <= entry[j].valid;
                    older[free_idx][j] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
ooo_pkg.sv
reorder_buffer.sv
rename_regfile.sv
reservation_station.sv
int_alu.sv
core_ctrl_wb.sv
ooo_core_top.sv
tb_ooo_core.sv

// ==== tb_ooo_core.sv ====
`default_nettype none

`include "ooo_defs.svh"

module tb_ooo_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_INDEP     = 40;
    localparam int N_CHAIN     = 30;
    localparam int N_BR_GROUPS = 8;
    localparam int N_BRANCH    = 3 * N_BR_GROUPS + 3;
    localparam int N_ROUNDS    = 3;
    localparam int N_BURST     = N_ROUNDS * 15;
    localparam int TOTAL_INSTR = N_INDEP + N_CHAIN + N_BRANCH + N_BURST;
    localparam int WB_ACCESSES = 8;
    localparam int IDLE_CYCLES = 8;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_INSTR + 10 * WB_ACCESSES + IDLE_CYCLES + 40;

    logic                  clk;
    logic                  rst;
    ooo_pkg::dispatch_t    disp;
    logic                  dispatch_ready;
    ooo_pkg::commit_t      commit;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADDR_W-1:0] wb_adr;
    ooo_pkg::word_t        wb_dat_w;
    ooo_pkg::word_t        wb_dat_r;
    logic                  wb_ack;

    // Sequential model of the program
    ooo_pkg::word_t   model_regs [`NUM_REGS];
    ooo_pkg::tag_t    model_tag;
    int               ref_retired;
    int               ref_taken;
    ooo_pkg::commit_t exp_q [$];
    int               stall_cycles;
    int               max_in_flight;

    ooo_core_top ooo_core_top_inst (
        .clk            (clk),
        .rst            (rst),
        .disp           (disp),
        .dispatch_ready (dispatch_ready),
        .commit         (commit),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_commit(input string name, input ooo_pkg::commit_t exp,
                                input ooo_pkg::commit_t got);
        if (got !== exp) begin
            abort_run({$sformatf("** Error at %0d ns: %s expected tag=%0d rd=%0d value=%h",
                                 $time, name, exp.tag, exp.rd, exp.value),
                       $sformatf(" br=%b taken=%b, got tag=%0d rd=%0d value=%h br=%b taken=%b",
                                 exp.is_branch, exp.taken, got.tag, got.rd, got.value,
                                 got.is_branch, got.taken)});
        end
    endtask

    task automatic check_word(input string name, input ooo_pkg::word_t exp,
                              input ooo_pkg::word_t got);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0d ns: %s expected %h got %h",
                                $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0d ns: %s expected %b got %b",
                                $time, name, exp, got));
        end
    endtask

    function automatic ooo_pkg::dispatch_t make_instr(input ooo_pkg::op_e op, input int rd,
                                                      input int rs1, input int rs2,
                                                      input logic use_imm,
                                                      input ooo_pkg::word_t imm);
        ooo_pkg::dispatch_t d;
        d.valid   = 1'b1;
        d.op      = op;
        d.rd      = ooo_pkg::reg_idx_t'(rd);
        d.rs1     = ooo_pkg::reg_idx_t'(rs1);
        d.rs2     = ooo_pkg::reg_idx_t'(rs2);
        d.use_imm = use_imm;
        d.imm     = imm;
        return d;
    endfunction

    function automatic ooo_pkg::op_e random_alu_op();
        ooo_pkg::op_e ops [9] = '{ooo_pkg::OP_ADD, ooo_pkg::OP_SUB, ooo_pkg::OP_AND,
                                  ooo_pkg::OP_OR, ooo_pkg::OP_XOR, ooo_pkg::OP_SLT,
                                  ooo_pkg::OP_SLTU, ooo_pkg::OP_SLL, ooo_pkg::OP_SRL};
        return ops[$urandom_range(8, 0)];
    endfunction

    // Runs one instruction in program order, returns what must retire
    function automatic ooo_pkg::commit_t reference_exec(input ooo_pkg::dispatch_t d);
        ooo_pkg::commit_t c;
        ooo_pkg::word_t   a;
        ooo_pkg::word_t   b;
        ooo_pkg::word_t   r;
        logic             br;
        a  = model_regs[d.rs1];
        b  = d.use_imm ? d.imm : model_regs[d.rs2];
        r  = '0;
        br = 1'b0;
        case (d.op)
            ooo_pkg::OP_ADD:  r = a + b;
            ooo_pkg::OP_SUB:  r = a - b;
            ooo_pkg::OP_AND:  r = a & b;
            ooo_pkg::OP_OR:   r = a | b;
            ooo_pkg::OP_XOR:  r = a ^ b;
            ooo_pkg::OP_SLT:  r = ($signed(a) < $signed(b)) ? `XLEN'(1) : `XLEN'(0);
            ooo_pkg::OP_SLTU: r = (a < b) ? `XLEN'(1) : `XLEN'(0);
            ooo_pkg::OP_SLL:  r = a << b[$clog2(`XLEN)-1:0];
            ooo_pkg::OP_SRL:  r = a >> b[$clog2(`XLEN)-1:0];
            ooo_pkg::OP_LUI:  r = d.imm;
            ooo_pkg::OP_BEQ: begin
                br = 1'b1;
                r  = (a == b) ? `XLEN'(1) : `XLEN'(0);
            end
            ooo_pkg::OP_BNE: begin
                br = 1'b1;
                r  = (a != b) ? `XLEN'(1) : `XLEN'(0);
            end
            default: r = '0;
        endcase
        c.valid     = 1'b1;
        c.tag       = model_tag;
        c.rd        = br ? '0 : d.rd;
        c.value     = r;
        c.is_branch = br;
        c.taken     = br && (r != '0);
        if (!br && (d.rd != '0)) begin
            model_regs[d.rd] = r;
        end
        // Tags run 1 .. ROB_DEPTH-1
        model_tag = (model_tag == ooo_pkg::tag_t'(`ROB_DEPTH - 1)) ? ooo_pkg::tag_t'(1)
                                                                   : model_tag + 1'b1;
        ref_retired++;
        if (c.taken) ref_taken++;
        return c;
    endfunction

    // Called on a rising edge, returns on the edge where the packet is taken
    task automatic dispatch_one(input ooo_pkg::dispatch_t d);
        logic fired;
        fired = 1'b0;
        disp <= d;
        while (!fired) begin
            @(negedge clk);
            fired = dispatch_ready;
            if (!fired) stall_cycles++;
            @(posedge clk);
        end
        exp_q.push_back(reference_exec(d));
        if (exp_q.size() > max_in_flight) max_in_flight = exp_q.size();
        if (exp_q.size() > `ROB_DEPTH - 1) begin
            abort_run("More instructions in flight than the ROB can hold");
        end
    endtask

    task automatic wait_drain();
        disp <= '0;
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic wb_access(input logic we, input int adr, input ooo_pkg::word_t wdata,
                             output ooo_pkg::word_t rdata);
        logic acked;
        acked = 1'b0;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= `WB_ADDR_W'(adr);
        wb_dat_w <= wdata;
        while (!acked) begin
            @(negedge clk);
            acked = wb_ack;
            rdata = wb_dat_r;
            @(posedge clk);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_flag("wb_ack", 1'b0, wb_ack);   // One cycle only
        @(posedge clk);
    endtask

    task automatic wb_write(input int adr, input ooo_pkg::word_t data);
        ooo_pkg::word_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic read_expect(input int adr, input ooo_pkg::word_t exp, input string name);
        ooo_pkg::word_t got;
        wb_access(1'b0, adr, '0, got);
        check_word(name, exp, got);
    endtask

    always @(negedge clk) begin : compare_commits
        ooo_pkg::commit_t expected;
        if ((rst === 1'b1) && (commit.valid === 1'b1)) begin
            if (exp_q.size() == 0) begin
                abort_run("A commit arrived with no instruction outstanding");
            end else begin
                expected = exp_q.pop_front();
                check_commit("commit", expected, commit);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout, commits stopped arriving before the test ended");
    end

    initial begin : main
        int             prev;
        int             rd;
        int             ra;
        int             rb;
        ooo_pkg::word_t val;
        logic           same;
        void'($urandom(87));
        rst           = 1'b0;
        disp          = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        model_tag     = ooo_pkg::tag_t'(1);
        ref_retired   = 0;
        ref_taken     = 0;
        stall_cycles  = 0;
        max_in_flight = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_flag("dispatch_ready", 1'b0, dispatch_ready);
        check_flag("commit.valid", 1'b0, commit.valid);
        check_flag("wb_ack", 1'b0, wb_ack);
        @(posedge clk);

        // A pending packet must not be taken while disabled
        disp <= make_instr(ooo_pkg::OP_LUI, 1, 0, 0, 1'b0, 32'h1234_5000);
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_flag("dispatch_ready", 1'b0, dispatch_ready);
            @(posedge clk);
        end
        disp <= '0;
        wb_write(0, 1);
        read_expect(0, 1, "wb_dat_r (control)");

        for (int i = 0; i < N_INDEP; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                dispatch_one(make_instr(ooo_pkg::OP_LUI, $urandom_range(31, 1), 0, 0,
                                        1'b0, $urandom));
            end else begin
                dispatch_one(make_instr(random_alu_op(), $urandom_range(31, 1),
                                        $urandom_range(31, 0), $urandom_range(31, 0),
                                        $urandom_range(1, 0) == 1, $urandom));
            end
        end
        wait_drain();

        prev = $urandom_range(31, 1);
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = $urandom_range(31, 1);
            dispatch_one(make_instr(random_alu_op(), rd, prev,
                                    ($urandom_range(1, 0) == 1) ? prev : $urandom_range(31, 0),
                                    $urandom_range(3, 0) == 0, $urandom));
            prev = rd;
        end
        wait_drain();

        for (int g = 0; g < N_BR_GROUPS; g++) begin
            ra   = $urandom_range(15, 1);
            rb   = $urandom_range(31, 16);
            val  = $urandom;
            same = $urandom_range(1, 0) == 1;
            dispatch_one(make_instr(ooo_pkg::OP_LUI, ra, 0, 0, 1'b0, val));
            dispatch_one(make_instr(ooo_pkg::OP_LUI, rb, 0, 0, 1'b0,
                                    same ? val : val ^ (32'h1 << $urandom_range(31, 0))));
            dispatch_one(make_instr((g % 2 == 1) ? ooo_pkg::OP_BNE : ooo_pkg::OP_BEQ,
                                    $urandom_range(31, 1), ra, rb, 1'b0, '0));
        end
        // Write to x0, then compare x0 against zero
        dispatch_one(make_instr(ooo_pkg::OP_ADD, 0, 5, 0, 1'b1, 32'h0000_0055));
        dispatch_one(make_instr(ooo_pkg::OP_BEQ, 0, 0, 0, 1'b1, '0));
        dispatch_one(make_instr(ooo_pkg::OP_BNE, 0, 0, 0, 1'b0, '0));
        wait_drain();

        // LUIs pile up in the ROB behind a slow chain in the station
        stall_cycles  = 0;
        max_in_flight = 0;
        prev          = 1;
        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int i = 0; i < 8; i++) begin
                rd = $urandom_range(15, 1);
                dispatch_one(make_instr(random_alu_op(), rd, prev, $urandom_range(31, 0),
                                        $urandom_range(1, 0) == 1, $urandom));
                prev = rd;
            end
            for (int i = 0; i < 7; i++) begin
                dispatch_one(make_instr(ooo_pkg::OP_LUI, $urandom_range(31, 16), 0, 0,
                                        1'b0, $urandom));
            end
        end
        wait_drain();
        if ((stall_cycles == 0) || (max_in_flight != `ROB_DEPTH - 1)) begin
            abort_run($sformatf("Burst did not fill the ROB (peak %0d, %0d stall cycles)",
                                max_in_flight, stall_cycles));
        end

        read_expect(1, ref_retired, "wb_dat_r (retired count)");
        read_expect(2, ref_taken, "wb_dat_r (taken count)");
        wb_write(1, 0);
        wb_write(2, 0);
        read_expect(1, 0, "wb_dat_r (retired count)");
        read_expect(2, 0, "wb_dat_r (taken count)");

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
